/* poker_board.f */
+incdir+src
src/poker_pkg.sv
src/rom_boot_ctrl.sv
src/rom_store.sv
src/key_mapper.sv
src/sigma_delta_dac.sv
src/poker_board_top.sv
tb/tb_poker_board.sv

/* run_sim.sh */
#!/bin/sh
# Build the poker board testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f poker_board.f --top-module tb_poker_board \
	-Mdir "$BUILD_DIR" -o tb_poker_board
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/tb_poker_board" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The testbench prints its verdict into the log
if grep -q "TEST FAIL" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi

echo "Simulation passed"
exit 0

/* tb/tb_poker_board.sv */
/*
 * Poker board glue testbench
 * ROM download and readback, core reset, key mapping and sigma-delta DACs
 */

`include "poker_settings.svh"

module tb_poker_board;

	timeunit 1ns;
	timeprecision 100ps;

	import poker_pkg::*;

	localparam int ROM_DEPTH = 1 << `POKER_ROM_ADDR_BITS;

	// Mapped scancodes in panel order
	localparam scancode_t KEY_TABLE [0:10] = '{8'h76, 8'h11, 8'h14, 8'h29, 8'h16, 8'h1E,
		8'h26, 8'h25, 8'h2E, 8'h75, 8'h72};

	logic clk_sys = 1'b0;
	logic rst_n;
	logic dl_active;
	dl_write_t dl_wr;
	logic soft_reset;
	rom_addr_t rom_addr;
	logic rom_rd;
	rom_byte_t rom_data;
	logic core_reset;
	logic loaded;
	logic key_strobe;
	logic key_pressed;
	scancode_t key_code;
	poker_buttons_t buttons;
	audio_sample_t audio_l;
	audio_sample_t audio_r;
	logic audio_out_l;
	logic audio_out_r;

	logic [31:0] lcg_state;
	rom_byte_t rom_model [0:ROM_DEPTH-1];	// Expected ROM image
	rom_addr_t wr_addrs [$];	// Addresses written by the last download
	logic [`POKER_DAC_BITS:0] acc_model_l;
	logic [`POKER_DAC_BITS:0] acc_model_r;
	int check_count;
	int err_count;
	int timeout_count;

	poker_board_top poker_board_top_inst (
		.clk_sys	(clk_sys),
		.rst_n	(rst_n),
		.dl_active	(dl_active),
		.dl_wr	(dl_wr),
		.soft_reset	(soft_reset),
		.rom_addr	(rom_addr),
		.rom_rd	(rom_rd),
		.rom_data	(rom_data),
		.core_reset	(core_reset),
		.loaded	(loaded),
		.key_strobe	(key_strobe),
		.key_pressed	(key_pressed),
		.key_code	(key_code),
		.buttons	(buttons),
		.audio_l	(audio_l),
		.audio_r	(audio_r),
		.audio_out_l	(audio_out_l),
		.audio_out_r	(audio_out_r)
	);

	always #50 clk_sys = ~clk_sys;	// 100 ns period

	// ========================================================================
	// Reference models and helpers
	// ========================================================================

	function automatic logic [31:0] lcg_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Panel after one key event
	function automatic poker_buttons_t expect_buttons(input scancode_t code,
			input logic pressed, input poker_buttons_t prev);
		poker_buttons_t next;
		next = prev;
		case (code)
			8'h76: next.coin = pressed;
			8'h11: next.stand = pressed;
			8'h14: next.cancel = pressed;
			8'h29: next.deal = pressed;
			8'h16: next.hold[0] = pressed;
			8'h1E: next.hold[1] = pressed;
			8'h26: next.hold[2] = pressed;
			8'h25: next.hold[3] = pressed;
			8'h2E: next.hold[4] = pressed;
			8'h75: next.gamble_in = pressed;
			8'h72: next.gamble_out = pressed;
			default: next = prev;	// Not a panel key
		endcase
		return next;
	endfunction

	// Each one on the output takes a full-scale step off the error
	function automatic logic [`POKER_DAC_BITS:0] dac_next(input logic [`POKER_DAC_BITS:0] acc,
			input audio_sample_t s);
		int full_scale;
		int err;
		int total;
		logic out_bit;
		full_scale = 1 << `POKER_DAC_BITS;
		err = int'(acc) % full_scale;	// Left over from the last step
		total = err + int'(s);
		out_bit = (total >= full_scale);
		if (out_bit)
			total = total - full_scale;
		return {out_bit, total[`POKER_DAC_BITS-1:0]};
	endfunction

	task automatic check_value(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			err_count++;
			$display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#5;
	endtask

	task automatic wait_core_reset(input logic level, input int limit, input string what);
		int cycles;
		cycles = 0;
		while (core_reset !== level && cycles < limit) begin
			next_cycle();
			cycles++;
		end
		if (core_reset !== level) begin
			err_count++;
			timeout_count++;
			$display("Timeout at %0t ns: %s did not happen within %0d cycles",
				$time, what, limit);
		end
	endtask

	// DAC models start from reset and check both outputs on every cycle
	always @(posedge clk_sys) begin
		if (!rst_n) begin
			acc_model_l = '0;
			acc_model_r = '0;
		end else begin
			acc_model_l = dac_next(acc_model_l, audio_l);
			acc_model_r = dac_next(acc_model_r, audio_r);
			#1;
			check_value("audio_out_l", 32'(audio_out_l), 32'(acc_model_l[`POKER_DAC_BITS]));
			check_value("audio_out_r", 32'(audio_out_r), 32'(acc_model_r[`POKER_DAC_BITS]));
		end
	end

	// ========================================================================
	// Stimulus tasks
	// ========================================================================

	task automatic run_download(input int count, input logic loaded_exp);
		logic [31:0] r;
		dl_addr_t addr;
		rom_byte_t data;
		int i;
		wr_addrs.delete();
		dl_active = 1'b1;
		wait_core_reset(1'b1, 4, "core reset at the start of the download");
		for (i = 0; i < count; i++) begin
			r = lcg_rand();
			addr = r[31:32-`POKER_DL_ADDR_BITS];	// Upper bits must be ignored
			r = lcg_rand();
			data = r[23:24-`POKER_DATA_BITS];
			dl_wr.wr = 1'b1;
			dl_wr.addr = addr;
			dl_wr.data = data;
			rom_model[addr[`POKER_ROM_ADDR_BITS-1:0]] = data;	// Last write wins
			wr_addrs.push_back(addr[`POKER_ROM_ADDR_BITS-1:0]);
			next_cycle();
			check_value("core_reset during download", 32'(core_reset), 32'd1);
			check_value("loaded during download", 32'(loaded), 32'(loaded_exp));
		end
		dl_wr.wr = 1'b0;
		dl_active = 1'b0;
		wait_core_reset(1'b0, 4, "core reset release after the download");
		check_value("loaded after download", 32'(loaded), 32'd1);
	endtask

	task automatic read_back();
		rom_addr_t a;
		int i;
		a = '0;
		for (i = 0; i < wr_addrs.size(); i++) begin
			a = wr_addrs[i];
			rom_addr = a;
			rom_rd = 1'b1;
			next_cycle();
			check_value($sformatf("rom_data at %h", a), 32'(rom_data), 32'(rom_model[a]));
		end
		rom_rd = 1'b0;
		rom_addr = ~a;
		next_cycle();
		check_value("rom_data hold", 32'(rom_data), 32'(rom_model[a]));	// No read, no change
	endtask

	task automatic run_keys(input int count);
		logic [31:0] r;
		poker_buttons_t expected;
		scancode_t code;
		int i;
		int idx;
		expected = '0;
		for (i = 0; i < count; i++) begin
			r = lcg_rand();
			if (r[30]) begin
				idx = int'(r[27:24]) % 11;
				code = KEY_TABLE[idx];
			end else begin
				code = r[23:16];	// Mostly unmapped
			end
			key_code = code;
			key_pressed = r[29];
			key_strobe = 1'b1;
			expected = expect_buttons(code, r[29], expected);
			next_cycle();
			key_strobe = 1'b0;
			check_value($sformatf("buttons after code %h", code), 32'(buttons),
				32'(expected));
		end
	endtask

	task automatic run_dac(input int samples, input int hold);
		logic [31:0] r;
		int i;
		for (i = 0; i < samples; i++) begin
			r = lcg_rand();
			audio_l = r[31:32-`POKER_DAC_BITS];
			r = lcg_rand();
			audio_r = r[31:32-`POKER_DAC_BITS];
			repeat (hold) next_cycle();
		end
		audio_l = '0;
		audio_r = '0;
		next_cycle();
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial begin
		lcg_state = 32'd86585;
		check_count = 0;
		err_count = 0;
		timeout_count = 0;
		rst_n = 1'b0;
		dl_active = 1'b0;
		dl_wr = '0;
		soft_reset = 1'b0;
		rom_addr = '0;
		rom_rd = 1'b0;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = '0;
		audio_l = '0;
		audio_r = '0;

		repeat (10) next_cycle();
		rst_n = 1'b1;
		next_cycle();

		check_value("core_reset after reset", 32'(core_reset), 32'd1);
		check_value("loaded after reset", 32'(loaded), 32'd0);
		check_value("buttons after reset", 32'(buttons), 32'd0);
		check_value("rom_data after reset", 32'(rom_data), 32'd0);

		// First image
		run_download(512, 1'b0);
		read_back();

		// Soft reset round trip
		soft_reset = 1'b1;
		wait_core_reset(1'b1, 4, "core reset on soft reset");
		soft_reset = 1'b0;
		wait_core_reset(1'b0, 4, "core reset release after soft reset");
		check_value("loaded after soft reset", 32'(loaded), 32'd1);

		// Reload over a running core
		run_download(16, 1'b1);
		read_back();

		run_keys(200);
		run_dac(8, 300);

		$display("Checks: %0d, errors: %0d, of which timeouts: %0d",
			check_count, err_count, timeout_count);
		if (err_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* src/poker_board_top.sv */
/*
 * Draw-poker board glue, top level
 * ROM download and store, core reset, keyboard buttons and audio DACs
 * for an attached game core
 */

module poker_board_top (
	input  logic clk_sys,
	input  logic rst_n,

	// Host download
	input  logic dl_active,
	input  poker_pkg::dl_write_t dl_wr,
	input  logic soft_reset,

	// Game core ROM port and reset
	input  poker_pkg::rom_addr_t rom_addr,
	input  logic rom_rd,
	output poker_pkg::rom_byte_t rom_data,
	output logic core_reset,
	output logic loaded,

	// Keyboard events
	input  logic key_strobe,
	input  logic key_pressed,
	input  poker_pkg::scancode_t key_code,
	output poker_pkg::poker_buttons_t buttons,

	// Audio
	input  poker_pkg::audio_sample_t audio_l,
	input  poker_pkg::audio_sample_t audio_r,
	output logic audio_out_l,
	output logic audio_out_r
);

	// ========================================================================
	// Boot and program ROM
	// ========================================================================

	rom_boot_ctrl boot_ctrl (
		.clk_sys	(clk_sys),
		.rst_n	(rst_n),
		.dl_active	(dl_active),
		.soft_reset	(soft_reset),
		.core_reset	(core_reset),
		.loaded	(loaded)
	);

	rom_store rom (
		.clk_sys	(clk_sys),
		.rst_n	(rst_n),
		.dl_wr	(dl_wr),
		.dl_active	(dl_active),
		.rom_addr	(rom_addr),
		.rom_rd	(rom_rd),
		.rom_data	(rom_data)
	);

	// ========================================================================
	// Cabinet controls
	// ========================================================================

	key_mapper keys (
		.clk_sys	(clk_sys),
		.rst_n	(rst_n),
		.key_strobe	(key_strobe),
		.key_pressed	(key_pressed),
		.key_code	(key_code),
		.buttons	(buttons)
	);

	// ========================================================================
	// Audio outputs
	// ========================================================================

	sigma_delta_dac dac_l (
		.clk_sys	(clk_sys),
		.rst_n	(rst_n),
		.sample	(audio_l),
		.bit_out	(audio_out_l)
	);

	sigma_delta_dac dac_r (
		.clk_sys	(clk_sys),
		.rst_n	(rst_n),
		.sample	(audio_r),
		.bit_out	(audio_out_r)
	);

endmodule

/* src/sigma_delta_dac.sv */
/*
 * First-order sigma-delta DAC
 * Error-feedback modulator, one audio word in, a 1-bit stream out
 */

`include "poker_settings.svh"

module sigma_delta_dac (
	input  logic clk_sys,
	input  logic rst_n,
	input  poker_pkg::audio_sample_t sample,
	output logic bit_out
);

	import poker_pkg::*;

	localparam int ACC_BITS = `POKER_DAC_BITS + 1;

	logic [ACC_BITS-1:0] acc;	// Carry on top, residue below
	logic [ACC_BITS-1:0] acc_sum;
	audio_sample_t residue;

	// Quantization error left over from the previous step
	assign residue = acc[`POKER_DAC_BITS-1:0];
	assign acc_sum = {1'b0, residue} + {1'b0, sample};

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			acc <= '0;
		else
			acc <= acc_sum;
	end

	// Registered carry, ones density follows sample / 2^DAC_BITS
	assign bit_out = acc[`POKER_DAC_BITS];

endmodule

/* src/key_mapper.sv */
/*
 * Keyboard to cabinet buttons
 * Turns scancode make/break events into held button levels
 */

module key_mapper (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic key_strobe,
	input  logic key_pressed,
	input  poker_pkg::scancode_t key_code,
	output poker_pkg::poker_buttons_t buttons
);

	import poker_pkg::*;

	// ========================================================================
	// Scancode table, PS/2 set 2
	// ========================================================================

	localparam scancode_t KEY_ESC = 8'h76;	// Coin
	localparam scancode_t KEY_LALT = 8'h11;	// Stand
	localparam scancode_t KEY_LCTRL = 8'h14;	// Cancel
	localparam scancode_t KEY_SPACE = 8'h29;	// Deal
	localparam scancode_t KEY_1 = 8'h16;
	localparam scancode_t KEY_2 = 8'h1E;
	localparam scancode_t KEY_3 = 8'h26;
	localparam scancode_t KEY_4 = 8'h25;
	localparam scancode_t KEY_5 = 8'h2E;
	localparam scancode_t KEY_UP = 8'h75;	// Gamble in
	localparam scancode_t KEY_DOWN = 8'h72;	// Gamble out

	// Each button keeps its level until its own break code
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			buttons <= '0;
		end else if (key_strobe) begin
			case (key_code)
				KEY_ESC:
					buttons.coin <= key_pressed;
				KEY_LALT:
					buttons.stand <= key_pressed;
				KEY_LCTRL:
					buttons.cancel <= key_pressed;
				KEY_SPACE:
					buttons.deal <= key_pressed;

				// Hold row on the digit keys
				KEY_1:
					buttons.hold[0] <= key_pressed;
				KEY_2:
					buttons.hold[1] <= key_pressed;
				KEY_3:
					buttons.hold[2] <= key_pressed;
				KEY_4:
					buttons.hold[3] <= key_pressed;
				KEY_5:
					buttons.hold[4] <= key_pressed;

				KEY_UP:
					buttons.gamble_in <= key_pressed;
				KEY_DOWN:
					buttons.gamble_out <= key_pressed;
				default: begin
					// Unmapped key, panel unchanged
				end
			endcase
		end
	end

endmodule

/* src/rom_store.sv */
/*
 * Program ROM store
 * On-chip byte memory, filled by the host download, read by the game core
 */

`include "poker_settings.svh"

module rom_store (
	input  logic clk_sys,
	input  logic rst_n,
	input  poker_pkg::dl_write_t dl_wr,
	input  logic dl_active,
	input  poker_pkg::rom_addr_t rom_addr,
	input  logic rom_rd,
	output poker_pkg::rom_byte_t rom_data
);

	import poker_pkg::*;

	localparam int ROM_DEPTH = 1 << `POKER_ROM_ADDR_BITS;

	rom_byte_t mem [0:ROM_DEPTH-1];
	rom_addr_t wr_addr;
	logic wr_en;

	// Loader address is wider than the ROM, keep the low bits only
	assign wr_addr = dl_wr.addr[`POKER_ROM_ADDR_BITS-1:0];
	assign wr_en = dl_wr.wr & dl_active;

	// ========================================================================
	// Download write port
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (wr_en)
			mem[wr_addr] <= dl_wr.data;
	end

	// ========================================================================
	// Core read port
	// ========================================================================

	// Old byte on a same-address collision
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			rom_data <= '0;
		else if (rom_rd)
			rom_data <= mem[rom_addr];
	end

endmodule

/* src/rom_boot_ctrl.sv */
/*
 * Boot controller
 * Follows the host download, remembers a finished load and drives the
 * registered reset of the game core
 */

module rom_boot_ctrl (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic dl_active,
	input  logic soft_reset,
	output logic core_reset,
	output logic loaded
);

	import poker_pkg::*;

	logic dl_active_q;	// Previous dl_active for edge detect
	logic dl_rise;
	logic dl_fall;
	boot_state_t state;
	boot_state_t state_next;

	assign dl_rise = dl_active & ~dl_active_q;
	assign dl_fall = ~dl_active & dl_active_q;

	// ========================================================================
	// Download tracking FSM
	// ========================================================================

	always_comb begin
		state_next = state;
		case (state)
			boot_empty: begin
				if (dl_rise)
					state_next = boot_loading;
			end
			boot_loading: begin
				if (dl_fall)
					state_next = boot_ready;	// Image complete
			end
			boot_ready: begin
				if (dl_rise)
					state_next = boot_loading;	// Reload over a running core
			end
			default: state_next = boot_empty;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dl_active_q <= 1'b0;
			state <= boot_empty;
			loaded <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			state <= state_next;
			if (state == boot_loading && dl_fall)
				loaded <= 1'b1;	// Sticky across later downloads
		end
	end

	// Core runs only with a complete image and no soft reset request
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			core_reset <= 1'b1;
		else
			core_reset <= (state_next != boot_ready) | soft_reset;
	end

endmodule

/* src/poker_pkg.sv */
/*
 * Draw-poker board types
 * Vector typedefs, cabinet button bundle, download write and boot states
 */

`include "poker_settings.svh"

package poker_pkg;

	// Vectors with a meaning of their own
	typedef logic [`POKER_ROM_ADDR_BITS-1:0] rom_addr_t;
	typedef logic [`POKER_DATA_BITS-1:0] rom_byte_t;
	typedef logic [`POKER_DL_ADDR_BITS-1:0] dl_addr_t;
	typedef logic [7:0] scancode_t;	// PS/2 set 2 code
	typedef logic [`POKER_DAC_BITS-1:0] audio_sample_t;

	// Cabinet panel, one bit per button, 11 bits in all
	typedef struct packed {
		logic coin;
		logic stand;
		logic cancel;
		logic deal;
		logic [4:0] hold;	// Hold 1 in bit 0
		logic gamble_in;
		logic gamble_out;
	} poker_buttons_t;

	// One host download beat
	typedef struct packed {
		logic wr;
		dl_addr_t addr;
		rom_byte_t data;
	} dl_write_t;

	// Boot controller FSM
	typedef enum logic [1:0] {
		boot_empty,
		boot_loading,
		boot_ready
	} boot_state_t;

endpackage

/* src/poker_settings.svh */
/*
 * Draw-poker board glue widths
 * Address, data and audio widths shared by the package and the RTL
 */

`ifndef POKER_SETTINGS_SVH
`define POKER_SETTINGS_SVH

// ===========================================================================
// Program ROM
// ===========================================================================

`define POKER_ROM_ADDR_BITS 15	// 32 KiB of program ROM
`define POKER_DATA_BITS 8	// Byte-wide ROM

// Host loader address, upper bits beyond the ROM are dropped
`define POKER_DL_ADDR_BITS 25

// ===========================================================================
// Audio
// ===========================================================================

`define POKER_DAC_BITS 16	// Unsigned sample from the game core

`endif
